/* cpu16.f */
+incdir+include
logic/isaPkg.sv
logic/registerFile.sv
logic/fetchStage.sv
logic/decodeStage.sv
logic/executeStage.sv
logic/branchUnit.sv
logic/cpu16Top.sv
test/cpu16Checker.sv
test/cpu16Tb.sv

/* test/cpu16Tb.sv */
`timescale 1ns/1ps
`include "cpu16_defines.svh"

module cpu16Tb import isaPkg::*; ();

    localparam int          NUM_TESTS = 8;
    localparam int          PROG_LEN  = 16;
    localparam int          MARGIN    = 20;
    localparam logic [31:0] SEED      = 32'hc156_ec09;
    localparam logic [15:0] HALT_WORD = {`OPC_HALT, 13'd0};

    logic                      clk;
    logic                      reset;
    logic [`CPU_WORD_W-1:0]    instr;
    logic [`CPU_PC_W-1:0]      fetchAddr;
    logic                      writeEn;
    logic [`CPU_REG_SEL_W-1:0] writeReg;
    logic [`CPU_WORD_W-1:0]    writeData;
    logic                      zFlag;
    logic                      nFlag;
    logic                      vFlag;
    logic                      halted;

    // Expectations of the running test
    logic [3:0]           expCount;
    logic [7:0][2:0]      expRegs;
    logic [7:0][15:0]     expData;
    logic [2:0]           expFlags;
    logic [`CPU_PC_W-1:0] expHaltPc;
    int                   testErrors;
    logic                 haltSeen;

    // One table row per test
    string                nameTab [NUM_TESTS];
    logic [15:0]          progTab [NUM_TESTS][PROG_LEN];
    logic [7:0][2:0]      wbRegTab [NUM_TESTS];
    logic [7:0][15:0]     wbDataTab [NUM_TESTS];
    int                   wbCountTab [NUM_TESTS];
    int                   branchTab [NUM_TESTS];
    logic [2:0]           flagTab [NUM_TESTS];
    logic [`CPU_PC_W-1:0] haltPcTab [NUM_TESTS];

    logic [15:0] mem [PROG_LEN];
    logic [31:0] lfsr;
    int          row;
    int          pcIdx;
    int          cycles;
    int          cycleLimit;
    int          failedTests;

    cpu16Top dut_i (
        .clk(clk), .reset(reset), .instr(instr), .fetchAddr(fetchAddr),
        .writeEn(writeEn), .writeReg(writeReg), .writeData(writeData),
        .zFlag(zFlag), .nFlag(nFlag), .vFlag(vFlag), .halted(halted)
    );

    cpu16Checker check_i (
        .clk(clk), .reset(reset), .fetchAddr(fetchAddr), .writeEn(writeEn),
        .writeReg(writeReg), .writeData(writeData), .zFlag(zFlag), .nFlag(nFlag),
        .vFlag(vFlag), .halted(halted), .expCount(expCount), .expRegs(expRegs),
        .expData(expData), .expFlags(expFlags), .expHaltPc(expHaltPc),
        .testErrors(testErrors), .haltSeen(haltSeen)
    );

    always #10 clk = ~clk;

    // Instruction memory with HALT outside the program
    always @(negedge clk) begin
        instr <= (fetchAddr < PROG_LEN) ? mem[fetchAddr[3:0]] : HALT_WORD;
    end

    // Taps 32 22 2 1
    function automatic logic [31:0] lfsrStep(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic nextByte(output logic [7:0] b);
        for (int i = 0; i < 8; i++) begin
            lfsr = lfsrStep(lfsr);
            b = {b[6:0], lfsr[0]};
        end
    endtask

    function automatic logic [15:0] sext8(logic [7:0] b);
        return {{8{b[7]}}, b};
    endfunction

    // Z N V of x - y from the true signed difference
    function automatic logic [2:0] cmpFlags(logic [15:0] x, logic [15:0] y);
        int s;
        s = int'($signed(x)) - int'($signed(y));
        return {s[15:0] == 16'd0, s[15], (s > 32767) || (s < -32768)};
    endfunction

    function automatic instrWordT regInstr(logic [2:0] opc, logic [1:0] op, logic [2:0] rn,
                                           logic [2:0] rd, logic [1:0] sh, logic [2:0] rm);
        instrWordT w;
        w.regForm = {opc, op, rn, rd, sh, rm};
        return w;
    endfunction

    function automatic instrWordT immInstr(logic [2:0] opc, logic [1:0] op, logic [2:0] rc,
                                           logic [7:0] imm);
        instrWordT w;
        w.immForm = {opc, op, rc, imm};
        return w;
    endfunction

    task automatic emit(instrWordT w);
        progTab[row][pcIdx] = w;
        if (w.regForm.opcode == `OPC_BRANCH) begin
            branchTab[row]++;
        end
        pcIdx++;
    endtask

    task automatic expectWb(logic [2:0] r, logic [15:0] d);
        wbRegTab[row][wbCountTab[row]] = r;
        wbDataTab[row][wbCountTab[row]] = d;
        wbCountTab[row]++;
    endtask

    task automatic loadImm(logic [2:0] r, logic [7:0] imm);
        emit(immInstr(`OPC_MOV, `OP_MOV_IMM, r, imm));
        expectWb(r, sext8(imm));
    endtask

    task automatic startRow(string name);
        nameTab[row] = name;
        for (int a = 0; a < PROG_LEN; a++) begin
            progTab[row][a] = HALT_WORD;
        end
        pcIdx = 0;
        wbCountTab[row] = 0;
        branchTab[row] = 0;
    endtask

    // Fetch runs two words ahead of the HALT in execute
    task automatic endRow(logic [2:0] flags);
        int h;
        h = PROG_LEN;
        for (int a = PROG_LEN - 1; a >= 0; a--) begin
            if (progTab[row][a] == HALT_WORD) begin
                h = a;
            end
        end
        flagTab[row] = flags;
        haltPcTab[row] = h + 2;
        row++;
    endtask

    // CMP then a branch over one MOV into skipReg
    task automatic cmpBranch(logic [2:0] cond, logic [7:0] x, logic [7:0] y, bit taken,
                             logic [2:0] skipReg);
        loadImm(3'd1, x);
        loadImm(3'd2, y);
        emit(regInstr(`OPC_ALU, `ALU_CMP, 3'd1, 3'd0, `SH_NONE, 3'd2));
        emit(immInstr(`OPC_BRANCH, 2'b00, cond, 8'd1));
        emit(immInstr(`OPC_MOV, `OP_MOV_IMM, skipReg, 8'h5a));
        if (!taken) begin
            expectWb(skipReg, 16'h005a);
        end
    endtask

    // First pair always takes the branch
    task automatic branchRow(string name, logic [2:0] cond, logic [7:0] x1, logic [7:0] y1,
                             logic [7:0] x2, logic [7:0] y2, bit take2);
        startRow(name);
        cmpBranch(cond, x1, y1, 1'b1, 3'd3);
        loadImm(3'd4, 8'h44);
        cmpBranch(cond, x2, y2, take2, 3'd5);
        loadImm(3'd6, 8'h66);
        endRow(cmpFlags(sext8(x2), sext8(y2)));
    endtask

    task automatic buildTable();
        logic [7:0]  a;
        logic [7:0]  b;
        logic [15:0] va;
        logic [15:0] vb;
        row = 0;
        startRow("aluOps");
        nextByte(a);
        nextByte(b);
        va = sext8(a);
        vb = sext8(b);
        loadImm(3'd1, a);
        loadImm(3'd2, b);
        emit(regInstr(`OPC_ALU, `ALU_ADD, 3'd1, 3'd3, `SH_NONE, 3'd2));
        expectWb(3'd3, va + vb);
        emit(regInstr(`OPC_ALU, `ALU_AND, 3'd1, 3'd4, `SH_NONE, 3'd2));
        expectWb(3'd4, va & vb);
        emit(regInstr(`OPC_ALU, `ALU_MVN, 3'd1, 3'd5, `SH_NONE, 3'd2));
        expectWb(3'd5, ~vb);
        emit(regInstr(`OPC_ALU, `ALU_ADD, 3'd1, 3'd6, `SH_LSL1, 3'd2));
        expectWb(3'd6, va + (vb << 1));
        endRow(3'b000);
        startRow("movShift");
        nextByte(a);
        // Negative so LSR and ASR differ
        a[7] = 1'b1;
        va = sext8(a);
        loadImm(3'd1, a);
        emit(regInstr(`OPC_MOV, `OP_MOV_REG, 3'd0, 3'd2, `SH_NONE, 3'd1));
        expectWb(3'd2, va);
        emit(regInstr(`OPC_MOV, `OP_MOV_REG, 3'd0, 3'd3, `SH_LSL1, 3'd1));
        expectWb(3'd3, va << 1);
        emit(regInstr(`OPC_MOV, `OP_MOV_REG, 3'd0, 3'd4, `SH_LSR1, 3'd1));
        expectWb(3'd4, va >> 1);
        emit(regInstr(`OPC_MOV, `OP_MOV_REG, 3'd0, 3'd5, `SH_ASR1, 3'd1));
        expectWb(3'd5, $signed(va) >>> 1);
        endRow(3'b000);
        startRow("cmpHalt");
        loadImm(3'd1, 8'hff);
        emit(regInstr(`OPC_MOV, `OP_MOV_REG, 3'd0, 3'd2, `SH_LSR1, 3'd1));
        expectWb(3'd2, 16'h7fff);
        loadImm(3'd3, 8'hff);
        // 7fff minus ffff overflows into a negative result
        emit(regInstr(`OPC_ALU, `ALU_CMP, 3'd2, 3'd0, `SH_NONE, 3'd3));
        emit(regInstr(`OPC_ALU, `ALU_ADD, 3'd2, 3'd4, `SH_NONE, 3'd3));
        expectWb(3'd4, 16'h7ffe);
        emit(HALT_WORD);
        emit(immInstr(`OPC_MOV, `OP_MOV_IMM, 3'd5, 8'h55));
        endRow(3'b011);
        branchRow("b", `COND_ALWAYS, 8'd1, 8'd2, 8'd3, 8'd3, 1'b1);
        branchRow("beq", `COND_EQ, 8'd5, 8'd5, 8'd5, 8'd6, 1'b0);
        branchRow("bne", `COND_NE, 8'd5, 8'd6, 8'd7, 8'd7, 1'b0);
        branchRow("blt", `COND_LT, 8'hfd, 8'd4, 8'd4, 8'hfd, 1'b0);
        branchRow("ble", `COND_LE, 8'd2, 8'd2, 8'd9, 8'd2, 1'b0);
    endtask

    // Run limit in clock cycles from the table
    always @(posedge clk) begin
        cycles++;
        if (cycles > cycleLimit) begin
            $display("Timeout after %0d cycles with tests still running", cycles);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    initial begin
        clk         = 1'b0;
        reset       = 1'b1;
        instr       = '0;
        expCount    = '0;
        expRegs     = '0;
        expData     = '0;
        expFlags    = '0;
        expHaltPc   = '0;
        cycles      = 0;
        failedTests = 0;
        lfsr        = SEED;
        buildTable();
        cycleLimit = 0;
        for (int t = 0; t < NUM_TESTS; t++) begin
            cycleLimit += 8 + PROG_LEN + 2 * branchTab[t] + MARGIN;
        end
        for (int t = 0; t < NUM_TESTS; t++) begin
            reset = 1'b1;
            for (int a = 0; a < PROG_LEN; a++) begin
                mem[a] = progTab[t][a];
            end
            expCount  = wbCountTab[t][3:0];
            expRegs   = wbRegTab[t];
            expData   = wbDataTab[t];
            expFlags  = flagTab[t];
            expHaltPc = haltPcTab[t];
            repeat (8) @(negedge clk);
            reset = 1'b0;
            while (!halted) begin
                @(negedge clk);
            end
            // A few frozen cycles for the checker to watch
            repeat (3) @(negedge clk);
            if (testErrors == 0 && haltSeen) begin
                $display("%-9s ok, %0d writebacks", nameTab[t], wbCountTab[t]);
            end else begin
                failedTests++;
                $display("%-9s failed with %0d errors", nameTab[t], testErrors);
            end
        end
        $display("%0d tests run, %0d failed", NUM_TESTS, failedTests);
        if (failedTests == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

/* test/cpu16Checker.sv */
`timescale 1ns/1ps
`include "cpu16_defines.svh"

module cpu16Checker (
    input  logic                            clk,
    input  logic                            reset,
    input  logic [`CPU_PC_W-1:0]            fetchAddr,
    input  logic                            writeEn,
    input  logic [`CPU_REG_SEL_W-1:0]       writeReg,
    input  logic [`CPU_WORD_W-1:0]          writeData,
    input  logic                            zFlag,
    input  logic                            nFlag,
    input  logic                            vFlag,
    input  logic                            halted,
    input  logic [3:0]                      expCount,
    input  logic [7:0][`CPU_REG_SEL_W-1:0]  expRegs,
    input  logic [7:0][`CPU_WORD_W-1:0]     expData,
    input  logic [2:0]                      expFlags,
    input  logic [`CPU_PC_W-1:0]            expHaltPc,
    output int                              testErrors,
    output logic                            haltSeen
);

    int wbIdx;

    // DUT outputs sampled at the rising edge
    always @(posedge clk) begin
        if (reset) begin
            wbIdx      = 0;
            testErrors = 0;
            haltSeen   = 1'b0;
        end else if (haltSeen) begin
            // Frozen pipeline after HALT
            if (writeEn) begin
                $display("Writeback to r%0d after HALT reached execute", writeReg);
                testErrors++;
            end
            if (!halted) begin
                $display("halted went low without a reset");
                testErrors++;
            end
        end else begin
            if (writeEn) begin
                if (wbIdx >= expCount) begin
                    $display("Unexpected writeback of %h to r%0d", writeData, writeReg);
                    testErrors++;
                end else begin
                    if (writeReg !== expRegs[wbIdx]) begin
                        $display("ERR writeReg exp %h got %h", expRegs[wbIdx], writeReg);
                        testErrors++;
                    end
                    if (writeData !== expData[wbIdx]) begin
                        $display("ERR writeData exp %h got %h", expData[wbIdx], writeData);
                        testErrors++;
                    end
                end
                wbIdx++;
            end
            if (halted) begin
                haltSeen = 1'b1;
                if (wbIdx != expCount) begin
                    $display("Saw %0d writebacks before HALT, expected %0d", wbIdx, expCount);
                    testErrors++;
                end
                if ({zFlag, nFlag, vFlag} !== expFlags) begin
                    $display("ERR zFlag,nFlag,vFlag exp %h got %h", expFlags,
                             {zFlag, nFlag, vFlag});
                    testErrors++;
                end
            end
        end
        // PC parks two words past the HALT
        if (!reset && halted && fetchAddr !== expHaltPc) begin
            $display("ERR fetchAddr exp %h got %h", expHaltPc, fetchAddr);
            testErrors++;
        end
    end

endmodule

/* logic/cpu16Top.sv */
`timescale 1ns/1ps
`include "cpu16_defines.svh"

module cpu16Top import isaPkg::*; (
    input  logic                      clk,
    input  logic                      reset,
    input  logic [`CPU_WORD_W-1:0]    instr,
    output logic [`CPU_PC_W-1:0]      fetchAddr,
    output logic                      writeEn,
    output logic [`CPU_REG_SEL_W-1:0] writeReg,
    output logic [`CPU_WORD_W-1:0]    writeData,
    output logic                      zFlag,
    output logic                      nFlag,
    output logic                      vFlag,
    output logic                      halted
);

    instrWordT            idInstr;
    instrWordT            exInstr;
    logic [`CPU_PC_W-1:0] idPc;
    logic [`CPU_PC_W-1:0] exPc;
    logic [`CPU_PC_W-1:0] target;
    logic                 redirect;
    logic                 exRegWrite;
    logic                 exWriteImm;
    logic                 exAZero;
    logic                 exBImm;
    logic                 exLoadFlags;
    logic                 exIsBranch;

    fetchStage fetch_i (
        .clk(clk), .reset(reset), .instr(instr),
        .redirect(redirect), .target(target), .halted(halted),
        .fetchAddr(fetchAddr), .idInstr(idInstr), .idPc(idPc)
    );

    // halted already carries the EX halt bit
    decodeStage decode_i (
        .clk(clk), .reset(reset), .idInstr(idInstr), .idPc(idPc),
        .redirect(redirect), .exInstr(exInstr), .exPc(exPc),
        .exRegWrite(exRegWrite), .exWriteImm(exWriteImm),
        .exAZero(exAZero), .exBImm(exBImm), .exLoadFlags(exLoadFlags),
        .exIsBranch(exIsBranch), .exIsHalt(), .halted(halted)
    );

    executeStage execute_i (
        .clk(clk), .reset(reset), .exInstr(exInstr),
        .exRegWrite(exRegWrite), .exWriteImm(exWriteImm),
        .exAZero(exAZero), .exBImm(exBImm), .exLoadFlags(exLoadFlags),
        .writeEn(writeEn), .writeReg(writeReg), .writeData(writeData),
        .zFlag(zFlag), .nFlag(nFlag), .vFlag(vFlag)
    );

    // Branch resolves in EX against the committed flags
    branchUnit branch_i (
        .exInstr(exInstr), .exPc(exPc), .exIsBranch(exIsBranch),
        .zFlag(zFlag), .nFlag(nFlag), .vFlag(vFlag),
        .redirect(redirect), .target(target)
    );

endmodule

/* logic/branchUnit.sv */
`timescale 1ns/1ps
`include "cpu16_defines.svh"

module branchUnit import isaPkg::*; (
    input  instrWordT            exInstr,
    input  logic [`CPU_PC_W-1:0] exPc,
    input  logic                 exIsBranch,
    input  logic                 zFlag,
    input  logic                 nFlag,
    input  logic                 vFlag,
    output logic                 redirect,
    output logic [`CPU_PC_W-1:0] target
);

    logic                 condMet;
    logic                 lessThan;
    logic [`CPU_PC_W-1:0] offset;

    // Signed less-than after CMP
    assign lessThan = nFlag ^ vFlag;

    always_comb begin
        case (exInstr.immForm.rnCond)
            `COND_ALWAYS: condMet = 1'b1;
            `COND_EQ:     condMet = zFlag;
            `COND_NE:     condMet = !zFlag;
            `COND_LT:     condMet = lessThan;
            `COND_LE:     condMet = lessThan || zFlag;
            default:      condMet = 1'b0;
        endcase
    end

    assign redirect = exIsBranch && condMet;

    // Relative to the word after the branch, wraps at the PC width
    assign offset = {{(`CPU_PC_W-8){exInstr.immForm.imm8[7]}}, exInstr.immForm.imm8};
    assign target = exPc + 1'b1 + offset;

endmodule

/* logic/executeStage.sv */
`timescale 1ns/1ps
`include "cpu16_defines.svh"

module executeStage import isaPkg::*; (
    input  logic                      clk,
    input  logic                      reset,
    input  instrWordT                 exInstr,
    input  logic                      exRegWrite,
    input  logic                      exWriteImm,
    input  logic                      exAZero,
    input  logic                      exBImm,
    input  logic                      exLoadFlags,
    output logic                      writeEn,
    output logic [`CPU_REG_SEL_W-1:0] writeReg,
    output logic [`CPU_WORD_W-1:0]    writeData,
    output logic                      zFlag,
    output logic                      nFlag,
    output logic                      vFlag
);

    logic [`CPU_WORD_W-1:0] rnData;
    logic [`CPU_WORD_W-1:0] rmData;
    logic [`CPU_WORD_W-1:0] shifted;
    logic [`CPU_WORD_W-1:0] sxImm8;
    logic [`CPU_WORD_W-1:0] aOp;
    logic [`CPU_WORD_W-1:0] bOp;
    logic [`CPU_WORD_W-1:0] aluResult;
    logic                   aluOverflow;

    registerFile regs_i (
        .clk       (clk),
        .rnSel     (exInstr.regForm.rn),
        .rmSel     (exInstr.regForm.rm),
        .writeEn   (writeEn),
        .writeReg  (writeReg),
        .writeData (writeData),
        .rnData    (rnData),
        .rmData    (rmData)
    );

    // Shifter on Rm
    always_comb begin
        case (exInstr.regForm.shift)
            `SH_LSL1: shifted = {rmData[`CPU_WORD_W-2:0], 1'b0};
            `SH_LSR1: shifted = {1'b0, rmData[`CPU_WORD_W-1:1]};
            `SH_ASR1: shifted = {rmData[`CPU_WORD_W-1], rmData[`CPU_WORD_W-1:1]};
            default:  shifted = rmData;
        endcase
    end

    assign sxImm8 = {{(`CPU_WORD_W-8){exInstr.immForm.imm8[7]}}, exInstr.immForm.imm8};
    assign aOp    = exAZero ? '0 : rnData;
    assign bOp    = exBImm ? sxImm8 : shifted;

    // ALU, V only meaningful for add and subtract
    always_comb begin
        aluOverflow = 1'b0;
        case (exInstr.regForm.op)
            `ALU_ADD: begin
                aluResult   = aOp + bOp;
                aluOverflow = (aOp[`CPU_WORD_W-1] == bOp[`CPU_WORD_W-1])
                            && (aluResult[`CPU_WORD_W-1] != aOp[`CPU_WORD_W-1]);
            end
            `ALU_CMP: begin
                aluResult   = aOp - bOp;
                aluOverflow = (aOp[`CPU_WORD_W-1] != bOp[`CPU_WORD_W-1])
                            && (aluResult[`CPU_WORD_W-1] != aOp[`CPU_WORD_W-1]);
            end
            `ALU_AND: aluResult = aOp & bOp;
            default:  aluResult = ~bOp;
        endcase
    end

    // Writeback
    assign writeEn   = exRegWrite;
    assign writeReg  = exWriteImm ? exInstr.immForm.rnCond : exInstr.regForm.rd;
    assign writeData = exWriteImm ? bOp : aluResult;

    // Status register, only CMP updates it
    always_ff @(posedge clk) begin
        if (reset) begin
            zFlag <= 1'b0;
            nFlag <= 1'b0;
            vFlag <= 1'b0;
        end else if (exLoadFlags) begin
            zFlag <= (aluResult == '0);
            nFlag <= aluResult[`CPU_WORD_W-1];
            vFlag <= aluOverflow;
        end
    end

endmodule

/* logic/decodeStage.sv */
`timescale 1ns/1ps
`include "cpu16_defines.svh"

module decodeStage import isaPkg::*; (
    input  logic                 clk,
    input  logic                 reset,
    input  instrWordT            idInstr,
    input  logic [`CPU_PC_W-1:0] idPc,
    input  logic                 redirect,
    output instrWordT            exInstr,
    output logic [`CPU_PC_W-1:0] exPc,
    output logic                 exRegWrite,
    output logic                 exWriteImm,
    output logic                 exAZero,
    output logic                 exBImm,
    output logic                 exLoadFlags,
    output logic                 exIsBranch,
    output logic                 exIsHalt,
    output logic                 halted
);

    logic regWrite;
    logic writeImm;
    logic aZero;
    logic bImm;
    logic loadFlags;
    logic isBranch;
    logic isHalt;

    // Control table
    always_comb begin
        regWrite  = 1'b0;
        writeImm  = 1'b0;
        aZero     = 1'b0;
        bImm      = 1'b0;
        loadFlags = 1'b0;
        isBranch  = 1'b0;
        isHalt    = 1'b0;
        case (idInstr.regForm.opcode)
            `OPC_MOV: begin
                if (idInstr.regForm.op == `OP_MOV_IMM) begin
                    // Immediate goes in as B and straight to Rn
                    regWrite = 1'b1;
                    writeImm = 1'b1;
                    bImm     = 1'b1;
                end else if (idInstr.regForm.op == `OP_MOV_REG) begin
                    // 0 + shifted Rm through the adder
                    regWrite = 1'b1;
                    aZero    = 1'b1;
                end
            end
            `OPC_ALU: begin
                if (idInstr.regForm.op == `ALU_CMP) begin
                    loadFlags = 1'b1;
                end else begin
                    regWrite = 1'b1;
                end
            end
            `OPC_BRANCH: begin
                isBranch = 1'b1;
            end
            `OPC_HALT: begin
                isHalt = 1'b1;
            end
            default: begin
                // Unknown encodings and bubbles do nothing
                regWrite = 1'b0;
            end
        endcase
    end

    // ID/EX control bits, freeze once a HALT reaches EX
    always_ff @(posedge clk) begin
        if (reset || redirect) begin
            exRegWrite  <= 1'b0;
            exWriteImm  <= 1'b0;
            exAZero     <= 1'b0;
            exBImm      <= 1'b0;
            exLoadFlags <= 1'b0;
            exIsBranch  <= 1'b0;
            exIsHalt    <= 1'b0;
        end else if (!exIsHalt) begin
            exRegWrite  <= regWrite;
            exWriteImm  <= writeImm;
            exAZero     <= aZero;
            exBImm      <= bImm;
            exLoadFlags <= loadFlags;
            exIsBranch  <= isBranch;
            exIsHalt    <= isHalt;
        end
    end

    // ID/EX payload
    always_ff @(posedge clk) begin
        if (!exIsHalt) begin
            exInstr <= idInstr;
            exPc    <= idPc;
        end
    end

    assign halted = exIsHalt;

endmodule

/* logic/fetchStage.sv */
`timescale 1ns/1ps
`include "cpu16_defines.svh"

module fetchStage (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [`CPU_WORD_W-1:0] instr,
    input  logic                   redirect,
    input  logic [`CPU_PC_W-1:0]   target,
    input  logic                   halted,
    output logic [`CPU_PC_W-1:0]   fetchAddr,
    output logic [`CPU_WORD_W-1:0] idInstr,
    output logic [`CPU_PC_W-1:0]   idPc
);

    logic [`CPU_PC_W-1:0] pc;

    assign fetchAddr = pc;

    // Program counter
    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= '0;
        end else if (redirect) begin
            pc <= target;
        end else if (!halted) begin
            pc <= pc + 1'b1;
        end
    end

    // IF/ID, a zero word decodes as a bubble
    always_ff @(posedge clk) begin
        if (reset || redirect) begin
            idInstr <= '0;
        end else if (!halted) begin
            idInstr <= instr;
        end
    end

    // PC travels with its word, only meaningful for branches
    always_ff @(posedge clk) begin
        if (!halted) begin
            idPc <= pc;
        end
    end

endmodule

/* logic/registerFile.sv */
`timescale 1ns/1ps
`include "cpu16_defines.svh"

module registerFile (
    input  logic                      clk,
    input  logic [`CPU_REG_SEL_W-1:0] rnSel,
    input  logic [`CPU_REG_SEL_W-1:0] rmSel,
    input  logic                      writeEn,
    input  logic [`CPU_REG_SEL_W-1:0] writeReg,
    input  logic [`CPU_WORD_W-1:0]    writeData,
    output logic [`CPU_WORD_W-1:0]    rnData,
    output logic [`CPU_WORD_W-1:0]    rmData
);

    logic [`CPU_WORD_W-1:0] regs [`CPU_NUM_REGS];

    always_ff @(posedge clk) begin
        if (writeEn) begin
            regs[writeReg] <= writeData;
        end
    end

    // Reads are combinational, a write shows up next cycle
    assign rnData = regs[rnSel];
    assign rmData = regs[rmSel];

endmodule

/* logic/isaPkg.sv */
`include "cpu16_defines.svh"

package isaPkg;

    // Three-register layout used by MOV Rd,Rm and the ALU group
    typedef struct packed {
        logic [2:0]                  opcode;
        logic [1:0]                  op;
        logic [`CPU_REG_SEL_W-1:0]   rn;
        logic [`CPU_REG_SEL_W-1:0]   rd;
        logic [1:0]                  shift;
        logic [`CPU_REG_SEL_W-1:0]   rm;
    } regFormT;

    // Immediate layout for MOV Rn,#imm8 and branches (cond sits where Rn is)
    typedef struct packed {
        logic [2:0]                  opcode;
        logic [1:0]                  op;
        logic [`CPU_REG_SEL_W-1:0]   rnCond;
        logic [7:0]                  imm8;
    } immFormT;

    typedef union packed {
        regFormT regForm;
        immFormT immForm;
    } instrWordT;

endpackage

/* include/cpu16_defines.svh */
`ifndef CPU16_DEFINES_SVH
`define CPU16_DEFINES_SVH

// Datapath and address widths
`define CPU_WORD_W 16
`define CPU_PC_W 9
`define CPU_REG_SEL_W 3
`define CPU_NUM_REGS 8

// Major opcodes, instruction bits [15:13]
`define OPC_MOV 3'b110
`define OPC_ALU 3'b101
`define OPC_BRANCH 3'b001
`define OPC_HALT 3'b111

// MOV sub-codes in the op field
`define OP_MOV_IMM 2'b10
`define OP_MOV_REG 2'b00

// ALU operation, taken straight from the op field
`define ALU_ADD 2'b00
`define ALU_CMP 2'b01
`define ALU_AND 2'b10
`define ALU_MVN 2'b11

// Shifter control on the Rm operand
`define SH_NONE 2'b00
`define SH_LSL1 2'b01
`define SH_LSR1 2'b10
`define SH_ASR1 2'b11

// Branch conditions, held in the Rn field of a branch
`define COND_ALWAYS 3'd0
`define COND_EQ 3'd1
`define COND_NE 3'd2
`define COND_LT 3'd3
`define COND_LE 3'd4

`endif
